/* tb/agc_input.mem */
// Columns: polls_not_done info1 info2 info3 exp_scale exp_offset
// Line 0 holds the start settings, each later line is one loop iteration
00000000 00000000 00000000 00000000 00000708 00000000
00000002 00040000 00000064 00000032 000006EA FFFFFFE7
00000000 00010000 00000010 00000030 00000708 00000000
00000001 00021FFF 00000020 00000023 00000708 00000000
00000003 00046000 00000050 00000010 000006EA FFFFFFE7
00000000 0003E000 00000060 0000005B 000006CC FFFFFFE7
00000002 00000000 00000000 00000040 000006EA 00000000
00000001 0001E000 00000007 00000000 00000708 FFFFFFE7

/* all.f */
+incdir+source
source/agc_pkg.sv
source/agc_loop_fsm.sv
source/agc_seq_counter.sv
source/agc_info_store.sv
source/agc_update_calc.sv
source/host_reg_port.sv
source/agc_ctrl_top.sv
tb/agc_chk.sv
tb/agc_target_model.sv
tb/agc_scoreboard.sv
tb/tb_top.sv

/* tb/tb_top.sv */
`include "agc_macros.svh"

module tb_top
    import agc_pkg::*;
;

    localparam int N_LINES     = 8;
    localparam int CLK_PERIOD  = 8;
    localparam int ITER_CYCLES = 200;      // Generous bound on one loop iteration
    localparam int TIMEOUT     = (N_LINES * ITER_CYCLES + 200) * CLK_PERIOD;

    logic          wb_clk_i = 1'b0;
    logic          arst_n_i = 1'b0;
    host_bus_req_t host_req = '0;
    host_bus_rsp_t host_rsp;
    agc_bus_req_t  agc_req;
    agc_bus_rsp_t  agc_rsp;
    int            err_cnt;
    int            bus_cnt;
    int            host_cnt;
    int            host_sent = 0;
    int            tb_err = 0;
    int            total_err;
    logic          bus_done;

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    agc_ctrl_top dut0 (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .agc_req_o  (agc_req),
        .agc_rsp_i  (agc_rsp)
    );

    agc_target_model #(.N_LINES(N_LINES)) model0 (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .agc_req_i (agc_req),
        .agc_rsp_o (agc_rsp)
    );

    agc_scoreboard #(.N_LINES(N_LINES)) sb0 (
        .wb_clk_i   (wb_clk_i),
        .agc_req_i  (agc_req),
        .agc_rsp_i  (agc_rsp),
        .host_req_i (host_req),
        .host_rsp_i (host_rsp),
        .err_cnt_o  (err_cnt),
        .bus_cnt_o  (bus_cnt),
        .host_cnt_o (host_cnt),
        .bus_done_o (bus_done)
    );

    bind agc_loop_fsm agc_chk chk0 (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .agc_req_i (agc_req_o),
        .agc_rsp_i (agc_rsp_i)
    );

    // One host transfer held until ack and followed by a short idle gap
    task automatic host_access(input logic we, input logic [7:0] adr);
        @(posedge wb_clk_i);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: 32'h5a5a_a5a5};
        host_sent++;
        @(posedge wb_clk_i);
        while (!host_rsp.ack) @(posedge wb_clk_i);
        host_req <= '0;
        repeat (2) @(posedge wb_clk_i);
    endtask

    initial begin
        repeat (4) @(posedge wb_clk_i);
        arst_n_i <= 1'b1;

        wait (bus_done);
        repeat (4) @(posedge wb_clk_i);

        host_access(1'b0, 8'h40);    // Scale step
        host_access(1'b0, 8'h44);    // Offset step
        host_access(1'b0, 8'h00);
        host_access(1'b0, 8'h04);
        host_access(1'b0, 8'h10);
        host_access(1'b0, 8'h14);
        host_access(1'b0, 8'h18);    // Past the last info word
        host_access(1'b0, 8'h3c);
        host_access(1'b1, 8'h08);
        host_access(1'b0, 8'h08);    // Write data must not land
        repeat (4) @(posedge wb_clk_i);

        if (host_cnt != host_sent) begin
            tb_err++;
            $display("Host port answered %0d of %0d transfers", host_cnt, host_sent);
        end
        total_err = err_cnt + tb_err + dut0.u_loop.chk0.fail_cnt;
        $display("bus transfers %0d, host transfers %0d, errors %0d, assertion failures %0d",
                 bus_cnt, host_cnt, err_cnt + tb_err, dut0.u_loop.chk0.fail_cnt);
        if (total_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish after %0d time units", TIMEOUT);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb/agc_scoreboard.sv */
`include "agc_macros.svh"

module agc_scoreboard
    import agc_pkg::*;
#(
    parameter int N_LINES = 8
) (
    input  logic          wb_clk_i,
    input  agc_bus_req_t  agc_req_i,
    input  agc_bus_rsp_t  agc_rsp_i,
    input  host_bus_req_t host_req_i,
    input  host_bus_rsp_t host_rsp_i,
    output int            err_cnt_o,
    output int            bus_cnt_o,
    output int            host_cnt_o,
    output logic          bus_done_o
);

    typedef struct packed {
        logic        we;
        logic [21:0] adr;
        logic [31:0] dat;
    } exp_txn_t;

    logic [31:0] stim_mem [0:N_LINES*6-1];
    exp_txn_t    exp_q [$];
    logic        built = 1'b0;
    logic        host_active = 1'b0;
    logic        host_we;
    logic [7:0]  host_adr;
    int          host_lat;

    task automatic expect_txn(input logic we, input logic [21:0] adr, input logic [31:0] dat);
        exp_q.push_back('{we: we, adr: adr, dat: dat});
    endtask

    task automatic expect_update(input int line);
        expect_txn(1'b1, `AGC_ADR_SCALE, stim_mem[line*6 + 4]);
        expect_txn(1'b1, `AGC_ADR_OFFSET, stim_mem[line*6 + 5]);
        expect_txn(1'b1, `AGC_ADR_CTRL, `AGC_CMD_LOAD);
        expect_txn(1'b1, `AGC_ADR_CTRL, `AGC_CMD_APPLY);
    endtask

    // Host readback once the loop is parked after the last iteration
    function automatic logic [31:0] host_expect(input logic [7:0] adr);
        int         last;
        logic [3:0] sel;
        last = N_LINES - 1;
        sel  = adr[5:2];
        if (adr[6]) begin
            if (sel == 4'd0) return 32'(`AGC_SCALE_DELTA);
            if (sel == 4'd1) return 32'(`AGC_OFFSET_DELTA);
            return '0;
        end
        case (sel)
            4'd0:             return 32'(last);
            4'd1, 4'd2, 4'd3: return stim_mem[last*6 + sel];
            4'd4:             return stim_mem[last*6 + 4];
            4'd5:             return stim_mem[last*6 + 5] & 32'h0000_ffff;
            default:          return '0;
        endcase
    endfunction

    initial begin
        err_cnt_o  = 0;
        bus_cnt_o  = 0;
        host_cnt_o = 0;
        bus_done_o = 1'b0;
        $readmemh("tb/agc_input.mem", stim_mem);
        expect_update(0);
        for (int i = 1; i < N_LINES; i++) begin
            expect_txn(1'b1, `AGC_ADR_CTRL, `AGC_CMD_RESET);
            expect_txn(1'b1, `AGC_ADR_CTRL, `AGC_CMD_START);
            for (int p = 0; p <= int'(stim_mem[i*6]); p++) begin
                expect_txn(1'b0, `AGC_ADR_CTRL, '0);      // Status polls
            end
            for (int w = 0; w < `AGC_INFO_WORDS; w++) begin
                expect_txn(1'b0, 22'(w * 4), '0);
            end
            expect_update(i);
        end
        built = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Downstream bus with one completed transfer per ack
    //////////////////////////////////////////////////////////////////////

    always @(negedge wb_clk_i) begin
        exp_txn_t e;
        if (agc_req_i.cyc && agc_rsp_i.ack) begin
            bus_cnt_o++;
            if (exp_q.size() == 0) begin
                err_cnt_o++;
                $display("Unexpected downstream transfer at adr %h", agc_req_i.adr);
            end else begin
                e = exp_q.pop_front();
                if (agc_req_i.we !== e.we) begin
                    err_cnt_o++;
                    $display("[FAIL] agc_req.we exp=%h got=%h", e.we, agc_req_i.we);
                end
                if (agc_req_i.adr !== e.adr) begin
                    err_cnt_o++;
                    $display("[FAIL] agc_req.adr exp=%h got=%h", e.adr, agc_req_i.adr);
                end
                if (e.we && agc_req_i.dat !== e.dat) begin
                    err_cnt_o++;
                    $display("[FAIL] agc_req.dat exp=%h got=%h", e.dat, agc_req_i.dat);
                end
            end
        end
        bus_done_o = built && (exp_q.size() == 0);
    end

    //////////////////////////////////////////////////////////////////////
    // Host port latency and read data
    //////////////////////////////////////////////////////////////////////

    always @(negedge wb_clk_i) begin
        if (host_active) begin
            host_lat++;
            if (host_rsp_i.ack) begin
                host_active = 1'b0;
                host_cnt_o++;
                if (host_lat != 2) begin
                    err_cnt_o++;
                    $display("Host ack came %0d cycles after the request", host_lat);
                end
                if (!host_we && host_rsp_i.dat !== host_expect(host_adr)) begin
                    err_cnt_o++;
                    $display("[FAIL] host_rsp.dat adr=%h exp=%h got=%h",
                             host_adr, host_expect(host_adr), host_rsp_i.dat);
                end
            end
        end else if (host_req_i.cyc && host_req_i.stb) begin
            host_active = 1'b1;
            host_lat    = 0;
            host_we     = host_req_i.we;
            host_adr    = host_req_i.adr;
        end else if (host_rsp_i.ack) begin
            err_cnt_o++;
            $display("Host ack seen without a request");
        end
    end

endmodule

/* tb/agc_target_model.sv */
`include "agc_macros.svh"

module agc_target_model
    import agc_pkg::*;
#(
    parameter int N_LINES = 8
) (
    input  logic         wb_clk_i,
    input  logic         arst_n_i,
    input  agc_bus_req_t agc_req_i,
    output agc_bus_rsp_t agc_rsp_o
);

    logic [31:0] stim_mem [0:N_LINES*6-1];
    logic [31:0] lfsr_q;
    logic [31:0] pend_scale;
    logic [31:0] pend_ofs;
    logic [31:0] cur_scale;
    logic [31:0] cur_ofs;
    logic [31:0] rd_dat;
    logic        busy;
    logic        stalled;    // No more acks once the last iteration is applied
    logic        info_phase; // Reads at address 0 are info word 0 after done
    int          delay_left;
    int          iter;
    int          polls_left;
    int          apply_cnt;

    initial begin
        $readmemh("tb/agc_input.mem", stim_mem);
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic answer_read(input logic [21:0] adr, output logic [31:0] d);
        logic [2:0] sel;
        sel = adr[4:2];
        d   = '0;
        if (!info_phase) begin
            if (polls_left > 0) begin
                polls_left--;                       // Measurement still busy
            end else begin
                d          = 32'd1 << `AGC_STATUS_DONE_BIT;
                info_phase = 1'b1;
            end
        end else begin
            case (sel)
                3'd0:             d = 32'(iter);
                3'd1, 3'd2, 3'd3: d = stim_mem[iter*6 + sel];
                3'd4:             d = cur_scale;
                3'd5:             d = cur_ofs;
                default:          d = '0;
            endcase
        end
    endtask

    task automatic take_write(input logic [21:0] adr, input logic [31:0] d);
        if (adr == `AGC_ADR_SCALE) begin
            pend_scale = d;
        end else if (adr == `AGC_ADR_OFFSET) begin
            pend_ofs = d;
        end else if (d == `AGC_CMD_RESET) begin
            iter++;
            info_phase = 1'b0;
            if (iter < N_LINES) polls_left = stim_mem[iter*6];
        end else if (d == `AGC_CMD_APPLY) begin
            cur_scale = pend_scale;
            cur_ofs   = pend_ofs;
            apply_cnt++;
            if (apply_cnt == N_LINES) stalled = 1'b1;
        end
    endtask

    always @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            agc_rsp_o  <= '0;
            lfsr_q     = 32'h3e16;
            busy       = 1'b0;
            stalled    = 1'b0;
            info_phase = 1'b0;
            delay_left = 0;
            iter       = 0;
            polls_left = 0;
            apply_cnt  = 0;
            pend_scale = '0;
            pend_ofs   = '0;
            cur_scale  = '0;
            cur_ofs    = '0;
        end else begin
            agc_rsp_o.ack <= 1'b0;
            if (agc_req_i.cyc && !agc_rsp_o.ack && !stalled) begin
                if (!busy) begin
                    // Two LFSR bits give a delay of 0 to 3 cycles
                    lfsr_q     = lfsr_next(lfsr_q);
                    delay_left = int'(lfsr_q[0]);
                    lfsr_q     = lfsr_next(lfsr_q);
                    delay_left = delay_left * 2 + int'(lfsr_q[0]);
                    busy       = 1'b1;
                end
                if (delay_left == 0) begin
                    busy = 1'b0;
                    if (agc_req_i.we) begin
                        take_write(agc_req_i.adr, agc_req_i.dat);
                        agc_rsp_o.dat <= '0;
                    end else begin
                        answer_read(agc_req_i.adr, rd_dat);
                        agc_rsp_o.dat <= rd_dat;
                    end
                    agc_rsp_o.ack <= 1'b1;
                end else begin
                    delay_left--;
                end
            end
        end
    end

endmodule

/* tb/agc_chk.sv */
module agc_chk
    import agc_pkg::*;
(
    input logic         wb_clk_i,
    input logic         arst_n_i,
    input agc_bus_req_t agc_req_i,
    input agc_bus_rsp_t agc_rsp_i
);

    int fail_cnt = 0;

    // Request fields frozen while waiting for ack
    req_held: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (agc_req_i.cyc && !agc_rsp_i.ack) |=> (agc_req_i == $past(agc_req_i)))
        else begin
            fail_cnt++;
            $error("Downstream request changed before it was acknowledged");
        end

    cyc_gap: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (agc_req_i.cyc && agc_rsp_i.ack) |=> !agc_req_i.cyc)
        else begin
            fail_cnt++;
            $error("Cycle stayed high after the acknowledge");
        end

    ack_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        agc_rsp_i.ack |-> agc_req_i.cyc)
        else begin
            fail_cnt++;
            $error("Acknowledge seen without an open cycle");
        end

endmodule

/* source/agc_ctrl_top.sv */
module agc_ctrl_top
    import agc_pkg::*;
(
    input  logic          wb_clk_i,
    input  logic          arst_n_i,
    input  host_bus_req_t host_req_i,
    output host_bus_rsp_t host_rsp_o,
    output agc_bus_req_t  agc_req_o,
    input  agc_bus_rsp_t  agc_rsp_i
);

    logic         boot_en;
    logic         boot_done;
    logic         idx_clr;
    logic         idx_step;
    logic [2:0]   idx;
    logic         capture;
    logic [31:0]  capture_dat;
    logic         calc;
    logic         apply;
    agc_setting_t setting;
    agc_info_t    info;

    agc_loop_fsm u_loop (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .agc_req_o     (agc_req_o),
        .agc_rsp_i     (agc_rsp_i),
        .boot_done_i   (boot_done),
        .idx_i         (idx),
        .boot_en_o     (boot_en),
        .idx_clr_o     (idx_clr),
        .idx_step_o    (idx_step),
        .capture_o     (capture),
        .capture_dat_o (capture_dat),
        .calc_o        (calc),
        .apply_o       (apply),
        .setting_i     (setting)
    );

    agc_seq_counter u_seq (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .boot_en_i   (boot_en),
        .boot_done_o (boot_done),
        .idx_clr_i   (idx_clr),
        .idx_step_i  (idx_step),
        .idx_o       (idx)
    );

    agc_info_store u_store (
        .wb_clk_i      (wb_clk_i),
        .arst_n_i      (arst_n_i),
        .capture_i     (capture),
        .capture_dat_i (capture_dat),
        .idx_i         (idx),
        .apply_i       (apply),
        .setting_i     (setting),
        .info_o        (info)
    );

    agc_update_calc u_calc (
        .wb_clk_i  (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .calc_i    (calc),
        .info_i    (info),
        .setting_o (setting)
    );

    host_reg_port u_host (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .info_i     (info)
    );

endmodule

/* source/host_reg_port.sv */
`include "agc_macros.svh"

module host_reg_port
    import agc_pkg::*;
(
    input  logic          wb_clk_i,
    input  logic          arst_n_i,
    input  host_bus_req_t host_req_i,
    output host_bus_rsp_t host_rsp_o,
    input  agc_info_t     info_i
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_WRITE,
        H_READ,
        H_ACK
    } host_state_e;

    localparam logic [15:0] OFST_STEP = 16'(`AGC_OFFSET_DELTA);

    host_state_e state_q;
    logic [31:0] rsp_dat_q;
    logic [3:0]  word_sel;

    assign word_sel = host_req_i.adr[5:2];

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= H_IDLE;
        end else begin
            case (state_q)
                H_IDLE: begin
                    if (host_req_i.cyc && host_req_i.stb) begin
                        state_q <= host_req_i.we ? H_WRITE : H_READ;
                    end
                end
                H_WRITE: state_q <= H_ACK;    // Write data is not stored
                H_READ:  state_q <= H_ACK;
                default: state_q <= H_IDLE;
            endcase
        end
    end

    // Response word, valid together with ack
    always_ff @(posedge wb_clk_i) begin
        if (state_q == H_READ) begin
            if (host_req_i.adr[6]) begin  // Loop step sizes
                case (word_sel)
                    4'd0:    rsp_dat_q <= 32'(`AGC_SCALE_DELTA);
                    4'd1:    rsp_dat_q <= {{16{OFST_STEP[15]}}, OFST_STEP};
                    default: rsp_dat_q <= '0;
                endcase
            end else if (word_sel < 4'(`AGC_INFO_WORDS)) begin
                rsp_dat_q <= info_i[word_sel];
            end else begin
                rsp_dat_q <= '0;
            end
        end
    end

    assign host_rsp_o.ack = (state_q == H_ACK);
    assign host_rsp_o.dat = rsp_dat_q;

endmodule

/* source/agc_update_calc.sv */
`include "agc_macros.svh"

module agc_update_calc
    import agc_pkg::*;
(
    input  logic         wb_clk_i,
    input  logic         arst_n_i,
    input  logic         calc_i,
    input  agc_info_t    info_i,
    output agc_setting_t setting_o
);

    localparam logic [31:0] BAND_HI    = 32'(`AGC_TARGET_RMS_SQ + `AGC_SCALE_ERR);
    localparam logic [31:0] BAND_LO    = 32'(`AGC_TARGET_RMS_SQ - `AGC_SCALE_ERR);
    localparam logic [31:0] SCALE_STEP = 32'(`AGC_SCALE_DELTA);
    localparam logic [31:0] OFST_STEP  = 32'(`AGC_OFFSET_DELTA);
    localparam logic [31:0] OFST_ERR   = 32'(`AGC_OFFSET_ERR);

    agc_setting_t setting_q;
    agc_setting_t setting_next;
    logic [31:0]  rms_sq;

    always_comb begin
        rms_sq       = info_i[1] >> `AGC_RMS_SHIFT;
        setting_next = setting_q;

        // Scale steps toward the band, never past the clamps
        if (rms_sq > BAND_HI) begin
            if (info_i[4] > `AGC_SCALE_MIN) setting_next.scale = 17'(info_i[4] - SCALE_STEP);
            else                            setting_next.scale = 17'(info_i[4]);
        end else if (rms_sq < BAND_LO) begin
            if (info_i[4] < `AGC_SCALE_MAX) setting_next.scale = 17'(info_i[4] + SCALE_STEP);
            else                            setting_next.scale = 17'(info_i[4]);
        end

        // Too many samples above the threshold pulls the offset down
        if (info_i[2] > info_i[3] + OFST_ERR) begin
            setting_next.offset = 16'(info_i[5] - OFST_STEP);
        end else if (info_i[3] > info_i[2] + OFST_ERR) begin
            setting_next.offset = 16'(info_i[5] + OFST_STEP);
        end
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            setting_q.scale  <= 17'(`AGC_START_SCALE);
            setting_q.offset <= 16'(`AGC_START_OFFSET);
        end else if (calc_i) begin
            setting_q <= setting_next;
        end
    end

    assign setting_o = setting_q;

endmodule

/* source/agc_info_store.sv */
`include "agc_macros.svh"

module agc_info_store
    import agc_pkg::*;
(
    input  logic         wb_clk_i,
    input  logic         arst_n_i,
    input  logic         capture_i,
    input  logic [31:0]  capture_dat_i,
    input  logic [2:0]   idx_i,
    input  logic         apply_i,
    input  agc_setting_t setting_i,
    output agc_info_t    info_o
);

    localparam int SCALE_WORD  = 4;
    localparam int OFFSET_WORD = 5;

    agc_info_t info_q;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            info_q <= '0;
        end else if (apply_i) begin
            // Next calculation starts from the settings just applied
            info_q[SCALE_WORD]  <= {15'h0, setting_i.scale};
            info_q[OFFSET_WORD] <= {16'h0, setting_i.offset};
        end else if (capture_i && idx_i < 3'(`AGC_INFO_WORDS)) begin
            info_q[idx_i] <= capture_dat_i;
        end
    end

    assign info_o = info_q;

endmodule

/* source/agc_seq_counter.sv */
`include "agc_macros.svh"

module agc_seq_counter (
    input  logic       wb_clk_i,
    input  logic       arst_n_i,
    input  logic       boot_en_i,
    output logic       boot_done_o,
    input  logic       idx_clr_i,
    input  logic       idx_step_i,
    output logic [2:0] idx_o
);

    localparam int BOOT_W = $clog2(`AGC_BOOT_DELAY + 1);

    logic [BOOT_W-1:0] boot_cnt_q;
    logic [2:0]        idx_q;

    // Boot delay, counts down once and then stays at zero
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_cnt_q <= BOOT_W'(`AGC_BOOT_DELAY);
        end else if (boot_en_i && boot_cnt_q != '0) begin
            boot_cnt_q <= boot_cnt_q - 1'b1;
        end
    end

    // Word index for info reads and setting writes
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idx_q <= '0;
        end else if (idx_clr_i) begin
            idx_q <= '0;
        end else if (idx_step_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign boot_done_o = (boot_cnt_q == '0);
    assign idx_o       = idx_q;

endmodule

/* source/agc_loop_fsm.sv */
`include "agc_macros.svh"

module agc_loop_fsm
    import agc_pkg::*;
(
    input  logic         wb_clk_i,
    input  logic         arst_n_i,
    output agc_bus_req_t agc_req_o,
    input  agc_bus_rsp_t agc_rsp_i,
    input  logic         boot_done_i,
    input  logic [2:0]   idx_i,
    output logic         boot_en_o,
    output logic         idx_clr_o,
    output logic         idx_step_o,
    output logic         capture_o,
    output logic [31:0]  capture_dat_o,
    output logic         calc_o,
    output logic         apply_o,
    input  agc_setting_t setting_i
);

    localparam logic [2:0] LAST_INFO = 3'(`AGC_INFO_WORDS);
    localparam logic [2:0] LAST_SET  = 3'd2;   // Scale word, then offset word

    agc_state_e   state_q;
    agc_state_e   state_next;
    comm_state_e  comm_q;
    agc_bus_req_t req_q;
    agc_bus_req_t req_next;
    logic [31:0]  rsp_dat_q;
    logic         ack_seen;
    logic         status_done;
    logic         seq_done;

    //////////////////////////////////////////////////////////////////////
    // Loop order and request forming
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state_q)
            ST_BOOT:        state_next = ST_WRITING;
            ST_RESETTING:   state_next = ST_POLLING;
            ST_POLLING:     state_next = ST_WAITING;
            ST_WAITING:     state_next = ST_READING;
            ST_READING:     state_next = ST_CALCULATING;
            ST_CALCULATING: state_next = ST_WRITING;
            ST_WRITING:     state_next = ST_LOADING;
            ST_LOADING:     state_next = ST_APPLYING;
            default:        state_next = ST_RESETTING;
        endcase
    end

    always_comb begin
        req_next     = '0;
        req_next.cyc = 1'b1;
        req_next.we  = 1'b1;
        req_next.adr = `AGC_ADR_CTRL;
        case (state_q)
            ST_RESETTING: req_next.dat = `AGC_CMD_RESET;
            ST_POLLING:   req_next.dat = `AGC_CMD_START;
            ST_WAITING:   req_next.we  = 1'b0;             // Status read
            ST_READING: begin
                req_next.we  = 1'b0;
                req_next.adr = {17'h0, idx_i, 2'b00};       // Word address
            end
            ST_WRITING: begin
                if (idx_i == 3'd0) begin
                    req_next.adr = `AGC_ADR_SCALE;
                    req_next.dat = {15'h0, setting_i.scale};
                end else begin
                    req_next.adr = `AGC_ADR_OFFSET;
                    req_next.dat = {{16{setting_i.offset[15]}}, setting_i.offset};
                end
            end
            ST_LOADING:   req_next.dat = `AGC_CMD_LOAD;
            ST_APPLYING:  req_next.dat = `AGC_CMD_APPLY;
            default:      req_next     = '0;
        endcase
    end

    // Multi word steps end once the index runs past the last word
    assign seq_done = (state_q == ST_READING && idx_i == LAST_INFO) ||
                      (state_q == ST_WRITING && idx_i == LAST_SET);

    assign ack_seen    = (comm_q == COMM_WAITING) && agc_rsp_i.ack;
    assign status_done = rsp_dat_q[`AGC_STATUS_DONE_BIT];

    //////////////////////////////////////////////////////////////////////
    // Outer loop with nested send / wait / process steps
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_BOOT;
            comm_q  <= COMM_SENDING;
            req_q   <= '0;
        end else begin
            case (state_q)
                ST_BOOT: begin
                    if (boot_done_i) state_q <= state_next;
                end
                ST_CALCULATING: state_q <= state_next;   // Single cycle
                default: begin
                    if (seq_done) begin
                        state_q <= state_next;
                    end else begin
                        case (comm_q)
                            COMM_SENDING: begin
                                req_q  <= req_next;        // Held until ack
                                comm_q <= COMM_WAITING;
                            end
                            COMM_WAITING: begin
                                if (agc_rsp_i.ack) begin
                                    req_q.cyc <= 1'b0;
                                    if (!req_q.we) begin
                                        comm_q <= COMM_PROCESSING;
                                    end else begin
                                        comm_q <= COMM_SENDING;
                                        // Setting writes advance through the index
                                        if (state_q != ST_WRITING) state_q <= state_next;
                                    end
                                end
                            end
                            default: begin
                                comm_q <= COMM_SENDING;
                                // Poll again unless the measurement has finished
                                if (state_q == ST_WAITING && status_done) begin
                                    state_q <= state_next;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // Read data captured on the ack edge
    always_ff @(posedge wb_clk_i) begin
        if (ack_seen) rsp_dat_q <= agc_rsp_i.dat;
    end

    assign agc_req_o     = req_q;
    assign boot_en_o     = (state_q == ST_BOOT);
    assign calc_o        = (state_q == ST_CALCULATING);
    assign capture_o     = (state_q == ST_READING) && (comm_q == COMM_PROCESSING);
    assign capture_dat_o = rsp_dat_q;
    assign apply_o       = (state_q == ST_APPLYING) && ack_seen;

    assign idx_clr_o  = seq_done ||
                        (state_q == ST_WAITING && comm_q == COMM_PROCESSING && status_done);
    assign idx_step_o = capture_o || (state_q == ST_WRITING && ack_seen);

endmodule

/* source/agc_pkg.sv */
`include "agc_macros.svh"

package agc_pkg;

    // Downstream bus towards the AGC block
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [21:0] adr;
        logic [31:0] dat;
    } agc_bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } agc_bus_rsp_t;

    // Host register bus
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } host_bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } host_bus_rsp_t;

    typedef struct packed {
        logic [16:0] scale;
        logic [15:0] offset;
    } agc_setting_t;

    // Words read back from the AGC block after a measurement
    typedef logic [`AGC_INFO_WORDS-1:0][31:0] agc_info_t;

    typedef enum logic [3:0] {
        ST_BOOT,
        ST_RESETTING,
        ST_POLLING,
        ST_WAITING,
        ST_READING,
        ST_CALCULATING,
        ST_WRITING,
        ST_LOADING,
        ST_APPLYING
    } agc_state_e;

    // Steps of a single downstream transfer
    typedef enum logic [1:0] {
        COMM_SENDING,
        COMM_WAITING,
        COMM_PROCESSING
    } comm_state_e;

endpackage

/* source/agc_macros.svh */
`ifndef AGC_MACROS_SVH
`define AGC_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Loop timing and targets
//////////////////////////////////////////////////////////////////////

`define AGC_BOOT_DELAY      31    // Cycles to wait before the first write
`define AGC_START_SCALE     1800
`define AGC_START_OFFSET    0

`define AGC_TIMESCALE_BITS  4
// Reduced RMS squared is info word 1 shifted by this amount
`define AGC_RMS_SHIFT       (17 - `AGC_TIMESCALE_BITS)
`define AGC_TARGET_RMS_SQ   16
`define AGC_SCALE_ERR       0     // Half width of the target band
`define AGC_OFFSET_ERR      5     // Allowed gt/lt count difference

`define AGC_SCALE_DELTA     30
`define AGC_OFFSET_DELTA    25

// Scale clamp limits
`define AGC_SCALE_MIN       32'h0000_012C
`define AGC_SCALE_MAX       32'h0001_FBD0

//////////////////////////////////////////////////////////////////////
// AGC block command codes and register map
//////////////////////////////////////////////////////////////////////

`define AGC_CMD_RESET       32'h0000_0004
`define AGC_CMD_START       32'h0000_0001
`define AGC_CMD_LOAD        32'h0000_0300
`define AGC_CMD_APPLY       32'h0000_0400

`define AGC_ADR_CTRL        22'h00_0000   // Control writes and status reads
`define AGC_ADR_SCALE       22'h00_0010
`define AGC_ADR_OFFSET      22'h00_0014

`define AGC_INFO_WORDS      6
`define AGC_STATUS_DONE_BIT 1             // Measurement finished flag

`endif
